/* rtl/tx_iq_pkg.sv */
// Shared transmit IQ definitions
// Sample word union, command word field positions, register addresses
package tx_iq_pkg;

  // One 32-bit sample word, read as an IQ pair or as CW key bytes
  typedef union packed {
    // I in the upper half, Q in the lower half
    struct packed {
      logic signed [15:0] i;
      logic signed [15:0] q;
    } iq;
    // Four bytes, key bit sits in bit 0 of each
    logic [3:0][7:0] cw;
  } tx_sample_u;

  // 48-bit command word from the host
  typedef logic [47:0] cmd_word_t;

  // Command word field positions
  localparam int CMD_CWX_BIT  = 41;
  localparam int CMD_RUN_BIT  = 40;
  localparam int CMD_ADDR_MSB = 38;
  localparam int CMD_ADDR_LSB = 33;
  localparam int CMD_PTT_BIT  = 32;
  localparam int CMD_DATA_MSB = 31;
  localparam int CMD_DATA_LSB = 0;

  // Register address width and map
  localparam int CMD_ADDR_W = 6;
  localparam logic [CMD_ADDR_W-1:0] CMD_ADDR_DRIVE = 6'd9;

  // Drive level width, taken from the low data bits
  localparam int DRIVE_W = 8;

endpackage

/* rtl/tx_frame_decode.sv */
// Nibble stream to sample word assembly
// Credit counter toward the sample FIFO and sticky overrun flag
module tx_frame_decode #(
  parameter int FIFO_DEPTH = 16,
  parameter int CREDIT_W   = 5
) (
  input  logic                  pi_tx_clk,
  input  logic                  rst_n,
  input  logic [3:0]            tx_data,
  input  logic                  tx_valid,
  input  logic                  credit_return,
  output tx_iq_pkg::tx_sample_u word,
  output logic                  word_valid,
  output logic                  tx_overrun
);

  // Partial word, most significant nibble first
  logic [31:0]         shift_reg;
  logic [2:0]          nib_cnt;
  logic [CREDIT_W-1:0] credit_cnt;

  logic word_done;
  logic have_credit;
  logic push_word;

  // Eighth nibble of a word arrives this cycle
  assign word_done   = tx_valid && (nib_cnt == 3'd7);
  assign have_credit = (credit_cnt != '0);
  // Push only with a credit in hand
  assign push_word   = word_done && have_credit;

  // ------------------------------------------------------------------
  // Nibble shifter and word register
  // ------------------------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (tx_valid) begin
      shift_reg <= {shift_reg[27:0], tx_data};
    end
    // Completed word lands with the last nibble
    if (word_done) begin
      word <= {shift_reg[27:0], tx_data};
    end
  end

  // Nibble position, wraps every eight valid nibbles
  always_ff @(posedge pi_tx_clk) begin
    if (!rst_n) begin
      nib_cnt <= '0;
    end else if (tx_valid) begin
      nib_cnt <= nib_cnt + 3'd1;
    end
  end

  // ------------------------------------------------------------------
  // Credit loop and overrun
  // ------------------------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (!rst_n) begin
      credit_cnt <= CREDIT_W'(FIFO_DEPTH);
      word_valid <= 1'b0;
      tx_overrun <= 1'b0;
    end else begin
      // Spend on push, refund on FIFO pop, both may land together
      credit_cnt <= credit_cnt - CREDIT_W'(push_word) + CREDIT_W'(credit_return);
      word_valid <= push_word;
      // Word without credit is dropped, flag stays until reset
      if (word_done && !have_credit) begin
        tx_overrun <= 1'b1;
      end
    end
  end

endmodule

/* rtl/tx_cmd_decode.sv */
// Command word decode
// Run, PTT, CW-from-stream enable and drive level register
module tx_cmd_decode (
  input  logic                 pi_tx_clk,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  input  tx_iq_pkg::cmd_word_t cmd_word,
  output logic                 run,
  output logic                 ptt,
  output logic                 cwx_enable,
  output logic [7:0]           drive_level
);

  // Field split of the incoming command
  logic [tx_iq_pkg::CMD_ADDR_W-1:0] cmd_addr;
  logic [31:0]                      cmd_data;
  logic                             drive_wr;

  assign cmd_addr = cmd_word[tx_iq_pkg::CMD_ADDR_MSB:tx_iq_pkg::CMD_ADDR_LSB];
  assign cmd_data = cmd_word[tx_iq_pkg::CMD_DATA_MSB:tx_iq_pkg::CMD_DATA_LSB];

  // Drive register write strobe
  assign drive_wr = cmd_valid && (cmd_addr == tx_iq_pkg::CMD_ADDR_DRIVE);

  // ------------------------------------------------------------------
  // Control bits, refreshed by every command
  // ------------------------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (!rst_n) begin
      run        <= 1'b0;
      ptt        <= 1'b0;
      cwx_enable <= 1'b0;
    end else if (cmd_valid) begin
      run        <= cmd_word[tx_iq_pkg::CMD_RUN_BIT];
      ptt        <= cmd_word[tx_iq_pkg::CMD_PTT_BIT];
      cwx_enable <= cmd_word[tx_iq_pkg::CMD_CWX_BIT];
    end
  end

  // ------------------------------------------------------------------
  // Drive level register
  // ------------------------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (!rst_n) begin
      drive_level <= '0;
    end else if (drive_wr) begin
      // Low data byte only, other addresses leave it alone
      drive_level <= cmd_data[tx_iq_pkg::DRIVE_W-1:0];
    end
  end

endmodule

/* rtl/tx_sample_fifo.sv */
// Synchronous sample FIFO on a register array
// Head word is always presented, one credit returned per pop
module tx_sample_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                  pi_tx_clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  tx_iq_pkg::tx_sample_u push_data,
  input  logic                  pop,
  output tx_iq_pkg::tx_sample_u pop_data,
  output logic                  empty,
  output logic                  credit_return
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  tx_iq_pkg::tx_sample_u mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      fill_count;
  logic                  do_pop;

  assign empty    = (fill_count == '0);
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];

  // Storage, written whenever the decoder pushes
  always_ff @(posedge pi_tx_clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ------------------------------------------------------------------
  // Pointers, fill level and credit pulse
  // ------------------------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill_count    <= '0;
      credit_return <= 1'b0;
    end else begin
      // Wrap explicitly so odd depths work too
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill_count    <= fill_count + CNT_W'(push) - CNT_W'(do_pop);
      // One credit back per word leaving
      credit_return <= do_pop;
    end
  end

endmodule

/* rtl/tx_iq_execute.sv */
// DAC strobe sample execution
// Drive scaling of IQ pairs or CW envelope from key bits, hole on empty FIFO
module tx_iq_execute (
  input  logic                  pi_tx_clk,
  input  logic                  rst_n,
  input  logic                  dac_strobe,
  input  logic                  empty,
  input  tx_iq_pkg::tx_sample_u pop_data,
  input  logic                  cwx_enable,
  input  logic [7:0]            drive_level,
  output logic                  pop,
  output logic                  exec_valid,
  output logic [15:0]           exec_i,
  output logic [15:0]           exec_q,
  output logic                  exec_key,
  output logic                  exec_hole
);

  // 16-bit signed times 9-bit positive drive
  logic signed [24:0] prod_i;
  logic signed [24:0] prod_q;
  logic               cw_key;
  logic [15:0]        next_i;
  logic [15:0]        next_q;

  // Take the head word whenever there is one
  assign pop = dac_strobe && !empty;

  assign prod_i = pop_data.iq.i * $signed({1'b0, drive_level});
  assign prod_q = pop_data.iq.q * $signed({1'b0, drive_level});

  // Any key bit in the four CW bytes
  assign cw_key = pop_data.cw[3][0] | pop_data.cw[2][0] |
                  pop_data.cw[1][0] | pop_data.cw[0][0];

  // ------------------------------------------------------------------
  // Output pair selection
  // ------------------------------------------------------------------
  always_comb begin
    next_i = '0;
    next_q = '0;
    if (empty) begin
      // Hole, zero pair
      next_i = '0;
    end else if (cwx_enable) begin
      // Carrier envelope follows the key, Q stays zero
      if (cw_key) begin
        next_i = {1'b0, drive_level, 7'b0};
      end
    end else begin
      // Scale by drive, drop 8 fraction bits
      next_i = 16'(prod_i >>> 8);
      next_q = 16'(prod_q >>> 8);
    end
  end

  // Control flags of the execute stage
  always_ff @(posedge pi_tx_clk) begin
    if (!rst_n) begin
      exec_valid <= 1'b0;
      exec_hole  <= 1'b0;
      exec_key   <= 1'b0;
    end else begin
      exec_valid <= dac_strobe;
      if (dac_strobe) begin
        exec_hole <= empty;
        exec_key  <= cwx_enable && cw_key && !empty;
      end
    end
  end

  // Pair payload, captured per strobe
  always_ff @(posedge pi_tx_clk) begin
    if (dac_strobe) begin
      exec_i <= next_i;
      exec_q <= next_q;
    end
  end

endmodule

/* rtl/tx_iq_result.sv */
// DAC output stage
// Transmit gating of the IQ pair and saturating underrun counter
module tx_iq_result (
  input  logic        pi_tx_clk,
  input  logic        rst_n,
  input  logic        exec_valid,
  input  logic [15:0] exec_i,
  input  logic [15:0] exec_q,
  input  logic        exec_key,
  input  logic        exec_hole,
  input  logic        run,
  input  logic        ptt,
  output logic        dac_valid,
  output logic [15:0] dac_i,
  output logic [15:0] dac_q,
  output logic        tx_on,
  output logic [7:0]  underrun_count
);

  // Transmit enable for the pair in flight
  logic tx_on_next;

  // PTT or a CW key both key the transmitter while running
  assign tx_on_next = run && (ptt || exec_key);

  // ------------------------------------------------------------------
  // Valid, transmit state and underrun count
  // ------------------------------------------------------------------
  always_ff @(posedge pi_tx_clk) begin
    if (!rst_n) begin
      dac_valid      <= 1'b0;
      tx_on          <= 1'b0;
      underrun_count <= '0;
    end else begin
      dac_valid <= exec_valid;
      if (exec_valid) begin
        tx_on <= tx_on_next;
      end
      // Counter sticks at full scale
      if (exec_valid && exec_hole && (underrun_count != 8'hff)) begin
        underrun_count <= underrun_count + 8'd1;
      end
    end
  end

  // Pair register, silent while not transmitting
  always_ff @(posedge pi_tx_clk) begin
    if (exec_valid) begin
      dac_i <= tx_on_next ? exec_i : '0;
      dac_q <= tx_on_next ? exec_q : '0;
    end
  end

endmodule

/* rtl/tx_iq_core.sv */
// Transmit IQ core top level
// Frame and command decode, sample FIFO, execute and result stages
module tx_iq_core #(
  parameter int FIFO_DEPTH = 16,
  parameter int CREDIT_W   = 5
) (
  input  logic                 pi_tx_clk,
  input  logic                 rst_n,
  input  logic [3:0]           tx_data,
  input  logic                 tx_valid,
  input  logic                 cmd_valid,
  input  tx_iq_pkg::cmd_word_t cmd_word,
  input  logic                 dac_strobe,
  output logic                 dac_valid,
  output logic [15:0]          dac_i,
  output logic [15:0]          dac_q,
  output logic                 tx_on,
  output logic                 tx_overrun,
  output logic [7:0]           underrun_count
);

  // Decode to FIFO
  tx_iq_pkg::tx_sample_u word;
  logic                  word_valid;
  logic                  credit_return;

  // FIFO to execute
  tx_iq_pkg::tx_sample_u pop_data;
  logic                  empty;
  logic                  pop;

  // Command settings
  logic       run;
  logic       ptt;
  logic       cwx_enable;
  logic [7:0] drive_level;

  // Execute to result
  logic        exec_valid;
  logic [15:0] exec_i;
  logic [15:0] exec_q;
  logic        exec_key;
  logic        exec_hole;

  // ------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------
  tx_frame_decode #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .CREDIT_W  (CREDIT_W)
  ) u_frame_decode (
    .pi_tx_clk    (pi_tx_clk),
    .rst_n        (rst_n),
    .tx_data      (tx_data),
    .tx_valid     (tx_valid),
    .credit_return(credit_return),
    .word         (word),
    .word_valid   (word_valid),
    .tx_overrun   (tx_overrun)
  );

  tx_cmd_decode u_cmd_decode (
    .pi_tx_clk  (pi_tx_clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .run        (run),
    .ptt        (ptt),
    .cwx_enable (cwx_enable),
    .drive_level(drive_level)
  );

  // Sample buffer, sized by the same depth as the credits
  tx_sample_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_sample_fifo (
    .pi_tx_clk    (pi_tx_clk),
    .rst_n        (rst_n),
    .push         (word_valid),
    .push_data    (word),
    .pop          (pop),
    .pop_data     (pop_data),
    .empty        (empty),
    .credit_return(credit_return)
  );

  // ------------------------------------------------------------------
  // Execute and result
  // ------------------------------------------------------------------
  tx_iq_execute u_iq_execute (
    .pi_tx_clk  (pi_tx_clk),
    .rst_n      (rst_n),
    .dac_strobe (dac_strobe),
    .empty      (empty),
    .pop_data   (pop_data),
    .cwx_enable (cwx_enable),
    .drive_level(drive_level),
    .pop        (pop),
    .exec_valid (exec_valid),
    .exec_i     (exec_i),
    .exec_q     (exec_q),
    .exec_key   (exec_key),
    .exec_hole  (exec_hole)
  );

  tx_iq_result u_iq_result (
    .pi_tx_clk     (pi_tx_clk),
    .rst_n         (rst_n),
    .exec_valid    (exec_valid),
    .exec_i        (exec_i),
    .exec_q        (exec_q),
    .exec_key      (exec_key),
    .exec_hole     (exec_hole),
    .run           (run),
    .ptt           (ptt),
    .dac_valid     (dac_valid),
    .dac_i         (dac_i),
    .dac_q         (dac_q),
    .tx_on         (tx_on),
    .underrun_count(underrun_count)
  );

endmodule

/* sim/tx_iq_core_assert.sv */
// Bound concurrent checks for the transmit IQ core
// DAC output timing, FIFO push against fill level, credit ceiling
module tx_iq_core_assert #(
  parameter int FIFO_DEPTH = 16,
  parameter int CREDIT_W   = 5
) (
  input logic                              pi_tx_clk,
  input logic                              rst_n,
  input logic                              dac_strobe,
  input logic                              dac_valid,
  input logic                              push,
  input logic [$clog2(FIFO_DEPTH + 1)-1:0] fill_count,
  input logic [CREDIT_W-1:0]               credit_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Failed assertion tally, watched from the testbench top
  int fail_count = 0;

  // Output pair exactly two cycles behind each strobe, and never without one
  dac_timing: assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    dac_valid == $past(dac_strobe, 2))
  else begin
    fail_count = fail_count + 1;
    $error("dac_valid did not follow dac_strobe by two cycles");
  end

  // Credits must keep the FIFO from ever being pushed while full
  no_push_full: assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    !(push && (fill_count == CNT_W'(FIFO_DEPTH))))
  else begin
    fail_count = fail_count + 1;
    $error("push seen while the sample FIFO was full");
  end

  // Refunds never exceed what was spent
  credit_ceiling: assert property (@(posedge pi_tx_clk) disable iff (!rst_n)
    credit_cnt <= CREDIT_W'(FIFO_DEPTH))
  else begin
    fail_count = fail_count + 1;
    $error("credit count rose above the FIFO depth");
  end

endmodule

/* sim/tb_tx_iq_core.sv */
// Testbench for the transmit IQ core
// Pattern file stimulus, DAC output and status checks, bound assertions
module tb_tx_iq_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int FIFO_DEPTH = 16;
  localparam int CREDIT_W   = 5;
  localparam int PAT_MAX    = 64;
  localparam int WAIT_LIMIT = 32;

  // Pattern line kinds, top nibble of each line
  localparam logic [3:0] KIND_CMD    = 4'h1;
  localparam logic [3:0] KIND_SAMPLE = 4'h2;
  localparam logic [3:0] KIND_STROBE = 4'h3;
  localparam logic [3:0] KIND_STATUS = 4'h4;
  localparam logic [3:0] KIND_BURST  = 4'h5;
  localparam logic [3:0] KIND_DRAIN  = 4'h6;

  logic        pi_tx_clk;
  logic        rst_n;
  logic [3:0]  tx_data;
  logic        tx_valid;
  logic        cmd_valid;
  logic [47:0] cmd_word;
  logic        dac_strobe;
  logic        dac_valid;
  logic [15:0] dac_i;
  logic [15:0] dac_q;
  logic        tx_on;
  logic        tx_overrun;
  logic [7:0]  underrun_count;

  logic [63:0] patterns [PAT_MAX];

  tx_iq_core #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .CREDIT_W  (CREDIT_W)
  ) u_dut (
    .pi_tx_clk     (pi_tx_clk),
    .rst_n         (rst_n),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid),
    .cmd_valid     (cmd_valid),
    .cmd_word      (cmd_word),
    .dac_strobe    (dac_strobe),
    .dac_valid     (dac_valid),
    .dac_i         (dac_i),
    .dac_q         (dac_q),
    .tx_on         (tx_on),
    .tx_overrun    (tx_overrun),
    .underrun_count(underrun_count)
  );

  // Checks on credits, FIFO fill and output timing inside the core
  bind tx_iq_core tx_iq_core_assert #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .CREDIT_W  (CREDIT_W)
  ) u_assert (
    .pi_tx_clk (pi_tx_clk),
    .rst_n     (rst_n),
    .dac_strobe(dac_strobe),
    .dac_valid (dac_valid),
    .push      (word_valid),
    .fill_count(u_sample_fifo.fill_count),
    .credit_cnt(u_frame_decode.credit_cnt)
  );

  initial begin
    pi_tx_clk = 1'b0;
    forever #2 pi_tx_clk = ~pi_tx_clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic string test_name(input logic [3:0] num);
    case (num)
      4'd1:    return "reset_state";
      4'd2:    return "drive_scaling";
      4'd3:    return "command_decode";
      4'd4:    return "cw_mode";
      4'd5:    return "credit_overrun";
      4'd6:    return "underrun";
      default: return "unnamed";
    endcase
  endfunction

  task automatic fail_run(input string what);
    $display("ERROR: %s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string test, input string sig,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH test=%s signal=%s expected=%0h actual=%0h",
               test, sig, expected, actual);
      fail_run("DUT output differs from the pattern file");
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge pi_tx_clk);
    #1;
  endtask

  task automatic send_cmd(input logic [47:0] word);
    cmd_word  = word;
    cmd_valid = 1'b1;
    next_cycle();
    cmd_valid = 1'b0;
    next_cycle();
  endtask

  // Eight nibbles, MSB first, random idle gaps in between
  task automatic send_word(input logic [31:0] word);
    int gap;
    for (int n = 7; n >= 0; n--) begin
      gap      = int'($urandom_range(2, 0));
      tx_valid = 1'b0;
      repeat (gap) next_cycle();
      tx_data  = word[n*4 +: 4];
      tx_valid = 1'b1;
      next_cycle();
    end
    tx_valid = 1'b0;
    // Word reaches the FIFO head two cycles later
    repeat (2) next_cycle();
  endtask

  task automatic strobe_check(input string test, input logic [15:0] exp_i,
                              input logic [15:0] exp_q, input logic exp_on);
    int waited;
    dac_strobe = 1'b1;
    next_cycle();
    dac_strobe = 1'b0;
    waited     = 0;
    while (dac_valid !== 1'b1) begin
      if (waited >= WAIT_LIMIT) begin
        fail_run("timed out waiting for dac_valid after a DAC strobe");
      end else begin
        next_cycle();
        waited++;
      end
    end
    check_value(test, "dac_i", {16'h0, exp_i}, {16'h0, dac_i});
    check_value(test, "dac_q", {16'h0, exp_q}, {16'h0, dac_q});
    check_value(test, "tx_on", {31'h0, exp_on}, {31'h0, tx_on});
    // Let dac_valid fall before the next strobe
    next_cycle();
  endtask

  // A failed bound assertion ends the run at the next edge
  always @(posedge pi_tx_clk) begin
    if (u_dut.u_assert.fail_count != 0) begin
      fail_run("a bound concurrent assertion failed");
    end
  end

  // ----------------------------------------------------------------------
  // Pattern sequencer
  // ----------------------------------------------------------------------
  initial begin
    int          idx;
    logic [63:0] line;
    logic [3:0]  kind;
    string       name;
    logic [15:0] ih;
    logic [15:0] ql;
    tx_data    = 4'h0;
    tx_valid   = 1'b0;
    cmd_valid  = 1'b0;
    cmd_word   = '0;
    dac_strobe = 1'b0;
    rst_n      = 1'b0;
    void'($urandom(84285));
    for (int i = 0; i < PAT_MAX; i++) begin
      patterns[i] = '0;
    end
    $readmemh("sim/tx_iq_patterns.mem", patterns);
    repeat (16) @(posedge pi_tx_clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    idx = 0;
    // Kind zero marks the end of the loaded lines
    while ((idx < PAT_MAX) && (patterns[idx][63:60] != 4'h0)) begin
      line = patterns[idx];
      kind = line[63:60];
      name = test_name(line[59:56]);
      ih   = line[31:16];
      ql   = line[15:0];
      case (kind)
        KIND_CMD:    send_cmd(line[47:0]);
        KIND_SAMPLE: send_word(line[31:0]);
        KIND_STROBE: strobe_check(name, ih, ql, line[32]);
        KIND_STATUS: begin
          check_value(name, "underrun_count", {24'h0, line[47:40]}, {24'h0, underrun_count});
          check_value(name, "tx_overrun", {31'h0, line[32]}, {31'h0, tx_overrun});
        end
        KIND_BURST: begin
          // Both halves step by the same amount per word
          for (int k = 0; k < int'(line[47:40]); k++) begin
            send_word({ih, ql});
            ih = ih + {8'h0, line[39:32]};
            ql = ql + {8'h0, line[39:32]};
          end
        end
        KIND_DRAIN: begin
          for (int k = 0; k < int'(line[47:40]); k++) begin
            strobe_check(name, ih, ql, 1'b1);
            ih = ih + {8'h0, line[39:32]};
            ql = ql + {8'h0, line[39:32]};
          end
        end
        default: fail_run("pattern file holds an unknown line kind");
      endcase
      idx++;
    end
    if (idx == 0) begin
      fail_run("pattern file held no usable lines");
    end else if (u_dut.u_assert.fail_count != 0) begin
      fail_run("a bound concurrent assertion failed");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

/* sim/tx_iq_patterns.mem */
// kind(1 cmd 2 sample 3 strobe 4 status 5 burst 6 drain) test(1-6) pad(2) payload(48)
// strobe tx_on[32] I[31:16] Q[15:0], status underruns[47:40] overrun[32], burst and drain count[47:40] step[39:32] word[31:0]
3_1_00_0000_0000_0000
4_1_00_0100_0000_0000
// run, ptt, drive 128
1_2_00_0113_0000_0080
2_2_00_0000_4000_2000
2_2_00_0000_C000_FFFE
2_2_00_0000_0003_7FFF
3_2_00_0001_2000_1000
3_2_00_0001_E000_FFFF
3_2_00_0001_0001_3FFF
// address 5 keeps the drive, then PTT off
1_3_00_010B_0000_0010
2_3_00_0000_1000_F000
3_3_00_0001_0800_F800
1_3_00_0100_0000_0000
2_3_00_0000_1000_1000
3_3_00_0000_0000_0000
// cwx with drive 0x40, no PTT
1_4_00_0312_0000_0040
2_4_00_0000_0000_0100
2_4_00_0000_FEFE_FEFE
3_4_00_0001_2000_0000
3_4_00_0000_0000_0000
// 17 words into 16 credits
1_5_00_0113_0000_0080
5_5_00_1102_0100_0200
4_5_00_0101_0000_0000
6_5_00_1001_0080_0100
3_6_00_0001_0000_0000
3_6_00_0001_0000_0000
4_6_00_0301_0000_0000

/* tx_iq_core.f */
rtl/tx_iq_pkg.sv
rtl/tx_frame_decode.sv
rtl/tx_cmd_decode.sv
rtl/tx_sample_fifo.sv
rtl/tx_iq_execute.sv
rtl/tx_iq_result.sv
rtl/tx_iq_core.sv
sim/tx_iq_core_assert.sv
sim/tb_tx_iq_core.sv

/* Makefile */
# Verilator simulation of the transmit IQ core

VERILATOR ?= verilator
TOP       ?= tb_tx_iq_core
FILELIST  ?= tx_iq_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

# Build, then run from the project root so the pattern path resolves
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
